// File: mips_id.f
+incdir+common
common/mips_id_pkg.sv
source/branch_unit.sv
decode/inst_decoder.sv
decode/operand_select.sv
source/id_stage.sv
tb/id_stage_assertions.sv
tb/tb_id_stage.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f mips_id.f --top-module tb_id_stage \
	--Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
grep -q "Simulation passed" sim.log

// File: tb/tb_id_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_id_defines.svh"

module tb_id_stage;

	localparam int MAX_CYCLES = 2000;
	localparam int N_RANDOM   = 400;

	logic                   clk;
	logic                   rst_i;
	logic                   inst_valid_i;
	mips_id_pkg::inst_t     inst_i;
	mips_id_pkg::word_t     pc_i;
	mips_id_pkg::word_t     reg1_data;
	mips_id_pkg::word_t     reg2_data;
	mips_id_pkg::reg_addr_t reg1_addr;
	mips_id_pkg::reg_addr_t reg2_addr;
	logic                   valid_o;
	mips_id_pkg::id_ex_t    id_ex_o;
	mips_id_pkg::branch_t   branch_o;

	mips_id_pkg::word_t     regs [32];
	mips_id_pkg::id_ex_t    exp_ex_q[$];
	mips_id_pkg::branch_t   exp_br_q[$];
	string                  name_q[$];
	mips_id_pkg::id_ex_t    last_ex;
	mips_id_pkg::branch_t   last_br;
	string                  last_name;
	logic                   have_last;
	logic                   strobe_seen;
	int                     cycles;
	int                     seed;

	id_stage i_dut (
		.clk          (clk),
		.rst_i        (rst_i),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.pc_i         (pc_i),
		.reg1_data_i  (reg1_data),
		.reg2_data_i  (reg2_data),
		.reg1_addr_o  (reg1_addr),
		.reg2_addr_o  (reg2_addr),
		.valid_o      (valid_o),
		.id_ex_o      (id_ex_o),
		.branch_o     (branch_o)
	);

	bind id_stage id_stage_assertions i_assertions (
		.clk      (clk),
		.rst_i    (rst_i),
		.strobe_i (inst_valid_i),
		.valid_i  (valid_o),
		.taken_i  (branch_o.taken),
		.target_i (branch_o.target)
	);

	// register file model answers in the same cycle
	assign reg1_data = regs[reg1_addr];
	assign reg2_data = regs[reg2_addr];

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic mips_id_pkg::id_ex_t with_op(input mips_id_pkg::id_ex_t e,
			input mips_id_pkg::alu_op_e o, input mips_id_pkg::alu_sel_e s);
		mips_id_pkg::id_ex_t r;
		r         = e;
		r.alu_op  = o;
		r.alu_sel = s;
		return r;
	endfunction

	// expected result straight from the decode rules
	function automatic void predict(input mips_id_pkg::inst_t inst, input mips_id_pkg::word_t pc,
			output mips_id_pkg::id_ex_t ex, output mips_id_pkg::branch_t br);
		logic [5:0]         op;
		logic [5:0]         fn;
		logic [4:0]         rs;
		logic [4:0]         rt;
		logic [4:0]         rd;
		mips_id_pkg::word_t rs_val;
		mips_id_pkg::word_t rt_val;
		mips_id_pkg::word_t imm_zx;
		mips_id_pkg::word_t imm_sx;
		mips_id_pkg::word_t pc4;
		mips_id_pkg::word_t cond_tgt;
		op       = inst[31:26];
		fn       = inst[5:0];
		rs       = inst[25:21];
		rt       = inst[20:16];
		rd       = inst[15:11];
		rs_val   = regs[rs];
		rt_val   = regs[rt];
		imm_zx   = {16'h0000, inst[15:0]};
		imm_sx   = {{16{inst[15]}}, inst[15:0]};
		pc4      = pc + 32'd4;
		cond_tgt = pc4 + (imm_sx << 2);
		ex       = '0;
		br       = '0;
		if (op == `MIPS_ID_OP_SPECIAL) begin
			ex.inst_valid = 1'b1;
			ex.wreg       = 1'b1;
			ex.wd         = rd;
			ex.reg1       = rs_val;
			ex.reg2       = rt_val;
			case (fn)
				`MIPS_ID_FN_AND:  ex = with_op(ex, mips_id_pkg::ALU_AND, mips_id_pkg::SEL_LOGIC);
				`MIPS_ID_FN_OR:   ex = with_op(ex, mips_id_pkg::ALU_OR, mips_id_pkg::SEL_LOGIC);
				`MIPS_ID_FN_XOR:  ex = with_op(ex, mips_id_pkg::ALU_XOR, mips_id_pkg::SEL_LOGIC);
				`MIPS_ID_FN_NOR:  ex = with_op(ex, mips_id_pkg::ALU_NOR, mips_id_pkg::SEL_LOGIC);
				`MIPS_ID_FN_SLT:  ex = with_op(ex, mips_id_pkg::ALU_SLT, mips_id_pkg::SEL_COMPARE);
				`MIPS_ID_FN_SLTU: ex = with_op(ex, mips_id_pkg::ALU_SLTU, mips_id_pkg::SEL_COMPARE);
				`MIPS_ID_FN_SLLV: ex = with_op(ex, mips_id_pkg::ALU_SLL, mips_id_pkg::SEL_SHIFT);
				`MIPS_ID_FN_SRLV: ex = with_op(ex, mips_id_pkg::ALU_SRL, mips_id_pkg::SEL_SHIFT);
				`MIPS_ID_FN_SRAV: ex = with_op(ex, mips_id_pkg::ALU_SRA, mips_id_pkg::SEL_SHIFT);
				`MIPS_ID_FN_ADD:  ex = with_op(ex, mips_id_pkg::ALU_ADD, mips_id_pkg::SEL_ADD);
				`MIPS_ID_FN_ADDU: ex = with_op(ex, mips_id_pkg::ALU_ADDU, mips_id_pkg::SEL_ADD);
				`MIPS_ID_FN_SUB:  ex = with_op(ex, mips_id_pkg::ALU_SUB, mips_id_pkg::SEL_ADD);
				`MIPS_ID_FN_SUBU: ex = with_op(ex, mips_id_pkg::ALU_SUBU, mips_id_pkg::SEL_ADD);
				`MIPS_ID_FN_SLL, `MIPS_ID_FN_SRL, `MIPS_ID_FN_SRA: begin
					ex.reg1 = {27'd0, inst[10:6]};  // shamt as operand 1
					if (fn == `MIPS_ID_FN_SLL)
						ex = with_op(ex, mips_id_pkg::ALU_SLL, mips_id_pkg::SEL_SHIFT);
					else if (fn == `MIPS_ID_FN_SRL)
						ex = with_op(ex, mips_id_pkg::ALU_SRL, mips_id_pkg::SEL_SHIFT);
					else
						ex = with_op(ex, mips_id_pkg::ALU_SRA, mips_id_pkg::SEL_SHIFT);
				end
				`MIPS_ID_FN_JR: begin
					ex.wreg = 1'b0;
					ex.wd   = '0;
					ex.reg2 = '0;
					br      = '{taken: 1'b1, target: rs_val};
				end
				`MIPS_ID_FN_JALR: begin
					ex      = with_op(ex, mips_id_pkg::ALU_LINK, mips_id_pkg::SEL_LINK);
					ex.reg1 = pc + 32'd8;
					ex.reg2 = '0;
					br      = '{taken: 1'b1, target: rs_val};
				end
				default: ex = '0;
			endcase
		end else if (op == `MIPS_ID_OP_REGIMM) begin
			if (rt == `MIPS_ID_RT_BLTZ || rt == `MIPS_ID_RT_BGEZ) begin
				ex.inst_valid = 1'b1;
				ex.reg1       = rs_val;
			end else if (rt == `MIPS_ID_RT_BLTZAL || rt == `MIPS_ID_RT_BGEZAL) begin
				ex            = with_op(ex, mips_id_pkg::ALU_LINK, mips_id_pkg::SEL_LINK);
				ex.inst_valid = 1'b1;
				ex.wreg       = 1'b1;
				ex.wd         = 5'd31;
				ex.reg1       = pc + 32'd8;  // links whether taken or not
			end
			if (ex.inst_valid)
				br.taken = rt[0] ? ($signed(rs_val) >= 0) : ($signed(rs_val) < 0);
			if (br.taken)
				br.target = cond_tgt;
		end else if (op == `MIPS_ID_OP_J || op == `MIPS_ID_OP_JAL) begin
			ex.inst_valid = 1'b1;
			if (op == `MIPS_ID_OP_JAL) begin
				ex      = with_op(ex, mips_id_pkg::ALU_LINK, mips_id_pkg::SEL_LINK);
				ex.wreg = 1'b1;
				ex.wd   = 5'd31;
				ex.reg1 = pc + 32'd8;
			end
			br = '{taken: 1'b1, target: {pc4[31:28], inst[25:0], 2'b00}};
		end else if (op >= `MIPS_ID_OP_BEQ && op <= `MIPS_ID_OP_BGTZ) begin
			ex.inst_valid = 1'b1;
			ex.reg1       = rs_val;
			case (op)
				`MIPS_ID_OP_BEQ:  br.taken = (rs_val == rt_val);
				`MIPS_ID_OP_BNE:  br.taken = (rs_val != rt_val);
				`MIPS_ID_OP_BLEZ: br.taken = ($signed(rs_val) <= 0);
				default:          br.taken = ($signed(rs_val) > 0);
			endcase
			if (op == `MIPS_ID_OP_BEQ || op == `MIPS_ID_OP_BNE)
				ex.reg2 = rt_val;
			if (br.taken)
				br.target = cond_tgt;
		end else if (op >= `MIPS_ID_OP_ADDI && op <= `MIPS_ID_OP_LUI) begin
			ex.inst_valid = 1'b1;
			ex.wreg       = 1'b1;
			ex.wd         = rt;
			ex.reg1       = rs_val;
			ex.reg2       = imm_sx;
			case (op)
				`MIPS_ID_OP_ADDI:  ex = with_op(ex, mips_id_pkg::ALU_ADD, mips_id_pkg::SEL_ADD);
				`MIPS_ID_OP_ADDIU: ex = with_op(ex, mips_id_pkg::ALU_ADDU, mips_id_pkg::SEL_ADD);
				`MIPS_ID_OP_SLTI:  ex = with_op(ex, mips_id_pkg::ALU_SLT, mips_id_pkg::SEL_COMPARE);
				`MIPS_ID_OP_SLTIU:
					ex = with_op(ex, mips_id_pkg::ALU_SLTU, mips_id_pkg::SEL_COMPARE);
				`MIPS_ID_OP_ANDI:  ex = with_op(ex, mips_id_pkg::ALU_AND, mips_id_pkg::SEL_LOGIC);
				`MIPS_ID_OP_XORI:  ex = with_op(ex, mips_id_pkg::ALU_XOR, mips_id_pkg::SEL_LOGIC);
				default:           ex = with_op(ex, mips_id_pkg::ALU_OR, mips_id_pkg::SEL_LOGIC);
			endcase
			if (op >= `MIPS_ID_OP_ANDI)
				ex.reg2 = (op == `MIPS_ID_OP_LUI) ? {inst[15:0], 16'h0000} : imm_zx;
		end
	endfunction

	task automatic check(input string name, input string field, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		assert (exp_v === act_v) else begin
			$display("CHECK FAILED %s %s expected %h actual %h", name, field, exp_v, act_v);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic compare_outputs(input string name, input mips_id_pkg::id_ex_t ex,
			input mips_id_pkg::branch_t br);
		check(name, "alu_op", 32'(ex.alu_op), 32'(id_ex_o.alu_op));
		check(name, "alu_sel", 32'(ex.alu_sel), 32'(id_ex_o.alu_sel));
		check(name, "reg1", ex.reg1, id_ex_o.reg1);
		check(name, "reg2", ex.reg2, id_ex_o.reg2);
		check(name, "wd", 32'(ex.wd), 32'(id_ex_o.wd));
		check(name, "wreg", 32'(ex.wreg), 32'(id_ex_o.wreg));
		check(name, "inst_valid", 32'(ex.inst_valid), 32'(id_ex_o.inst_valid));
		check(name, "taken", 32'(br.taken), 32'(branch_o.taken));
		check(name, "target", br.target, branch_o.target);
	endtask

	task automatic issue(input string name, input mips_id_pkg::inst_t inst,
			input mips_id_pkg::word_t pc);
		mips_id_pkg::id_ex_t  ex;
		mips_id_pkg::branch_t br;
		@(negedge clk);
		inst_valid_i = 1'b1;
		inst_i       = inst;
		pc_i         = pc;
		predict(inst, pc, ex, br);
		exp_ex_q.push_back(ex);
		exp_br_q.push_back(br);
		name_q.push_back(name);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			inst_valid_i = 1'b0;
			inst_i       = $random(seed);  // junk must not leak through
		end
	endtask

	function automatic mips_id_pkg::inst_t r_type(input logic [5:0] fn, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sa);
		return {6'b000000, rs, rt, rd, sa, fn};
	endfunction

	function automatic mips_id_pkg::inst_t i_type(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// strobe captured at each edge for the valid_o check
	always @(posedge clk) begin
		strobe_seen <= inst_valid_i && !rst_i;
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Simulation failed");
			$fatal(1);
		end
	end

	always @(negedge clk) begin
		if (!rst_i) begin
			check("strobe", "valid_o", 32'(strobe_seen), 32'(valid_o));
			if (valid_o) begin
				last_ex   = exp_ex_q.pop_front();
				last_br   = exp_br_q.pop_front();
				last_name = name_q.pop_front();
				have_last = 1'b1;
				compare_outputs(last_name, last_ex, last_br);
			end else if (have_last) begin
				compare_outputs($sformatf("hold after %s", last_name), last_ex, last_br);
			end
		end
	end

	initial begin
		logic [5:0]         op_tbl [14];
		logic [5:0]         fn_tbl [18];
		logic [4:0]         rt_tbl [4];
		logic [31:0]        r;
		mips_id_pkg::inst_t w;
		mips_id_pkg::word_t pc;
		op_tbl = '{6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07, 6'h08, 6'h09, 6'h0a, 6'h0b,
			6'h0c, 6'h0d, 6'h0e, 6'h0f};
		fn_tbl = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09, 6'h20, 6'h21,
			6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
		rt_tbl = '{5'h00, 5'h01, 5'h10, 5'h11};
		seed         = 32'hcff7;
		cycles       = 0;
		strobe_seen  = 1'b0;
		have_last    = 1'b0;
		rst_i        = 1'b1;
		inst_valid_i = 1'b0;
		inst_i       = '0;
		pc_i         = '0;
		for (int i = 0; i < 32; i++)
			regs[i] = $random(seed);
		regs[0]  = '0;
		regs[5]  = '0;
		regs[6]  = 32'hffff_fff0;
		regs[7]  = 32'h8000_0000;
		regs[9]  = regs[8];  // equal pair
		regs[10] = 32'd1;
		regs[11] = 32'h7fff_ffff;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;
		check("reset", "valid_o", 32'd0, 32'(valid_o));
		check("reset", "taken", 32'd0, 32'(branch_o.taken));

		for (int k = 0; k < 18; k++)
			issue($sformatf("r-form fn %h", fn_tbl[k]), r_type(fn_tbl[k], 5'd3, 5'd4, 5'd12,
				5'(k + 3)), 32'h0040_0000 + 32'(k * 4));
		issue("andi", i_type(6'h0c, 5'd6, 5'd13, 16'hf0f0), 32'h0040_1000);
		issue("ori", i_type(6'h0d, 5'd7, 5'd14, 16'h8001), 32'h0040_1004);
		issue("xori", i_type(6'h0e, 5'd2, 5'd15, 16'hffff), 32'h0040_1008);
		issue("lui", i_type(6'h0f, 5'd3, 5'd16, 16'h1234), 32'h0040_100c);
		issue("slti", i_type(6'h0a, 5'd6, 5'd17, 16'h8000), 32'h0040_1010);
		issue("sltiu", i_type(6'h0b, 5'd1, 5'd18, 16'hfff0), 32'h0040_1014);
		issue("addi", i_type(6'h08, 5'd11, 5'd19, 16'h7fff), 32'h0040_1018);
		issue("addiu", i_type(6'h09, 5'd4, 5'd20, 16'hfffc), 32'h0040_101c);
		idle(2);
		issue("j", {6'h02, 26'h3ff_ffff}, 32'hf000_0ffc);
		issue("jal", {6'h03, 26'h012_3456}, 32'h1000_2000);
		issue("jr", r_type(6'h08, 5'd7, 5'd0, 5'd0, 5'd0), 32'h0000_0100);
		issue("jalr", r_type(6'h09, 5'd3, 5'd0, 5'd25, 5'd0), 32'h0000_0200);
		issue("beq equal", i_type(6'h04, 5'd8, 5'd9, 16'hfff8), 32'h0000_0400);
		issue("beq differ", i_type(6'h04, 5'd8, 5'd10, 16'h0010), 32'h0000_0404);
		issue("bne", i_type(6'h05, 5'd8, 5'd10, 16'h8000), 32'h0001_0000);
		issue("blez zero", i_type(6'h06, 5'd5, 5'd0, 16'h0004), 32'h0000_0500);
		issue("blez neg", i_type(6'h06, 5'd7, 5'd0, 16'hffff), 32'h0000_0504);
		issue("blez pos", i_type(6'h06, 5'd11, 5'd0, 16'h0040), 32'h0000_0508);
		issue("bgtz pos", i_type(6'h07, 5'd10, 5'd0, 16'h0040), 32'h0000_050c);
		issue("bgtz zero", i_type(6'h07, 5'd0, 5'd0, 16'h0040), 32'h0000_0510);
		issue("bltz neg", i_type(6'h01, 5'd6, 5'h00, 16'hfff0), 32'h0000_0600);
		issue("bgez zero", i_type(6'h01, 5'd5, 5'h01, 16'h0020), 32'h0000_0604);
		issue("bltzal pos", i_type(6'h01, 5'd11, 5'h10, 16'h0020), 32'h0000_0608);
		issue("bgezal neg", i_type(6'h01, 5'd7, 5'h11, 16'h0020), 32'h0000_060c);
		issue("bgezal pos", i_type(6'h01, 5'd10, 5'h11, 16'hff00), 32'h0000_0610);
		idle(1);
		issue("bad opcode", i_type(6'h3f, 5'd3, 5'd4, 16'h1234), 32'h0000_0700);
		issue("bad funct", r_type(6'h3b, 5'd3, 5'd4, 5'd5, 5'd0), 32'h0000_0704);
		issue("bad regimm", i_type(6'h01, 5'd6, 5'h05, 16'h0010), 32'h0000_0708);
		idle(3);

		for (int i = 0; i < N_RANDOM; i++) begin
			r  = $random(seed);
			w  = $random(seed);
			pc = $random(seed);
			pc[1:0] = 2'b00;
			if (r[2:0] == 3'd1 || r[2:0] == 3'd2) begin
				w[31:26] = 6'h00;
				w[5:0]   = fn_tbl[int'(r[8:4]) % 18];
			end else if (r[2:0] == 3'd3) begin
				w[31:26] = 6'h01;
				w[20:16] = rt_tbl[r[10:9]];
			end else if (r[2:0] != 3'd0) begin
				w[31:26] = op_tbl[int'(r[15:12]) % 14];
			end
			issue($sformatf("random %0d", i), w, pc);
			if (r[19:17] == 3'd0)
				idle(int'(r[21:20]) + 1);
		end
		idle(4);
		if (exp_ex_q.size() != 0) begin
			$display("%0d results never appeared on valid_o", exp_ex_q.size());
			$display("Simulation failed");
			$fatal(1);
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: tb/id_stage_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module id_stage_assertions (
	input wire logic                clk,
	input wire logic                rst_i,
	input wire logic                strobe_i,
	input wire logic                valid_i,
	input wire logic                taken_i,
	input wire mips_id_pkg::word_t  target_i
);

	// one result per strobe, one cycle later
	valid_after_strobe: assert property (@(posedge clk) disable iff (rst_i)
		strobe_i |=> valid_i)
		else $error("valid_o missing one cycle after a strobe");

	no_valid_without_strobe: assert property (@(posedge clk) disable iff (rst_i)
		!strobe_i |=> !valid_i)
		else $error("valid_o high without a strobe");

	reset_clears: assert property (@(posedge clk)
		rst_i |=> !valid_i && !taken_i)
		else $error("valid_o or branch flag set after reset");

	target_zero_not_taken: assert property (@(posedge clk) disable iff (rst_i)
		valid_i && !taken_i |-> target_i == '0)
		else $error("branch target nonzero on a branch not taken");

endmodule

`default_nettype wire

// File: source/id_stage.sv
`timescale 1ns/100ps
`default_nettype none

module id_stage (
	input  logic                   clk,
	input  logic                   rst_i,
	input  logic                   inst_valid_i,
	input  mips_id_pkg::inst_t     inst_i,
	input  mips_id_pkg::word_t     pc_i,
	input  mips_id_pkg::word_t     reg1_data_i,
	input  mips_id_pkg::word_t     reg2_data_i,
	output mips_id_pkg::reg_addr_t reg1_addr_o,
	output mips_id_pkg::reg_addr_t reg2_addr_o,
	output logic                   valid_o,
	output mips_id_pkg::id_ex_t    id_ex_o,
	output mips_id_pkg::branch_t   branch_o
);

	mips_id_pkg::decode_t dec;
	mips_id_pkg::word_t   reg1;
	mips_id_pkg::word_t   reg2;
	mips_id_pkg::branch_t branch;
	mips_id_pkg::id_ex_t  id_ex_d;
	logic                 taken_q;
	mips_id_pkg::word_t   target_q;

	inst_decoder i_inst_decoder (
		.inst_i      (inst_i),
		.dec_o       (dec),
		.reg1_addr_o (reg1_addr_o),
		.reg2_addr_o (reg2_addr_o)
	);

	operand_select i_operand_select (
		.dec_i       (dec),
		.pc_i        (pc_i),
		.reg1_data_i (reg1_data_i),
		.reg2_data_i (reg2_data_i),
		.reg1_o      (reg1),
		.reg2_o      (reg2)
	);

	branch_unit i_branch_unit (
		.inst_i      (inst_i),
		.pc_i        (pc_i),
		.reg1_data_i (reg1_data_i),
		.reg2_data_i (reg2_data_i),
		.branch_o    (branch)
	);

	always_comb begin
		id_ex_d.alu_op     = dec.alu_op;
		id_ex_d.alu_sel    = dec.alu_sel;
		id_ex_d.reg1       = reg1;
		id_ex_d.reg2       = reg2;
		id_ex_d.wd         = dec.wd;
		id_ex_d.wreg       = dec.wreg;
		id_ex_d.inst_valid = dec.inst_valid;
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_o <= 1'b0;
			taken_q <= 1'b0;
		end else begin
			valid_o <= inst_valid_i;  // one cycle per strobe
			if (inst_valid_i) begin
				taken_q <= branch.taken;
			end
		end
	end

	// outputs hold between strobes
	always_ff @(posedge clk) begin
		if (inst_valid_i) begin
			id_ex_o  <= id_ex_d;
			target_q <= branch.target;
		end
	end

	assign branch_o.taken  = taken_q;
	assign branch_o.target = target_q;

endmodule

`default_nettype wire

// File: decode/operand_select.sv
`timescale 1ns/100ps
`default_nettype none

module operand_select (
	input  mips_id_pkg::decode_t dec_i,
	input  mips_id_pkg::word_t   pc_i,
	input  mips_id_pkg::word_t   reg1_data_i,
	input  mips_id_pkg::word_t   reg2_data_i,
	output mips_id_pkg::word_t   reg1_o,
	output mips_id_pkg::word_t   reg2_o
);

	mips_id_pkg::word_t pc_plus_8;

	// return address skips the delay slot
	assign pc_plus_8 = pc_i + mips_id_pkg::word_t'(8);

	always_comb begin
		if (dec_i.link) begin
			reg1_o = pc_plus_8;
		end else if (dec_i.reg1_read) begin
			reg1_o = reg1_data_i;
		end else begin
			reg1_o = dec_i.imm;  // shamt for shift by immediate
		end
	end

	always_comb begin
		if (dec_i.link) begin
			reg2_o = '0;
		end else if (dec_i.reg2_read) begin
			reg2_o = reg2_data_i;
		end else begin
			reg2_o = dec_i.imm;
		end
	end

endmodule

`default_nettype wire

// File: decode/inst_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_id_defines.svh"

module inst_decoder (
	input  mips_id_pkg::inst_t     inst_i,
	output mips_id_pkg::decode_t   dec_o,
	output mips_id_pkg::reg_addr_t reg1_addr_o,
	output mips_id_pkg::reg_addr_t reg2_addr_o
);

	mips_id_pkg::opcode_t   op;
	mips_id_pkg::funct_t    fn;
	mips_id_pkg::reg_addr_t rs;
	mips_id_pkg::reg_addr_t rt;
	mips_id_pkg::reg_addr_t rd;
	mips_id_pkg::shamt_t    shamt;
	mips_id_pkg::word_t     imm_zx;
	mips_id_pkg::word_t     imm_sx;
	mips_id_pkg::word_t     imm_hi;
	mips_id_pkg::word_t     imm_sh;

	localparam mips_id_pkg::reg_addr_t LINK_REG = `MIPS_ID_LINK_REG;

	assign op    = inst_i[31:26];
	assign rs    = inst_i[25:21];
	assign rt    = inst_i[20:16];
	assign rd    = inst_i[15:11];
	assign shamt = inst_i[10:6];
	assign fn    = inst_i[5:0];

	assign reg1_addr_o = rs;
	assign reg2_addr_o = rt;

	assign imm_zx = {{(`MIPS_ID_WORD_W-`MIPS_ID_IMM_W){1'b0}}, inst_i[15:0]};
	assign imm_sx = {{(`MIPS_ID_WORD_W-`MIPS_ID_IMM_W){inst_i[15]}}, inst_i[15:0]};
	assign imm_hi = {inst_i[15:0], {`MIPS_ID_IMM_W{1'b0}}};  // lui
	assign imm_sh = {{(`MIPS_ID_WORD_W-`MIPS_ID_REG_ADDR_W){1'b0}}, shamt};

	// register form, both ports read
	function automatic mips_id_pkg::decode_t r_form(
		input mips_id_pkg::alu_op_e   op_in,
		input mips_id_pkg::alu_sel_e  sel_in,
		input mips_id_pkg::reg_addr_t wd_in
	);
		mips_id_pkg::decode_t d;
		d            = '0;
		d.alu_op     = op_in;
		d.alu_sel    = sel_in;
		d.wd         = wd_in;
		d.wreg       = 1'b1;
		d.reg1_read  = 1'b1;
		d.reg2_read  = 1'b1;
		d.inst_valid = 1'b1;
		return d;
	endfunction

	function automatic mips_id_pkg::decode_t sh_form(
		input mips_id_pkg::alu_op_e   op_in,
		input mips_id_pkg::reg_addr_t wd_in,
		input mips_id_pkg::word_t     amt_in
	);
		mips_id_pkg::decode_t d;
		d           = r_form(op_in, mips_id_pkg::SEL_SHIFT, wd_in);
		d.reg1_read = 1'b0;  // shamt goes in as operand 1
		d.imm       = amt_in;
		return d;
	endfunction

	function automatic mips_id_pkg::decode_t i_form(
		input mips_id_pkg::alu_op_e   op_in,
		input mips_id_pkg::alu_sel_e  sel_in,
		input mips_id_pkg::reg_addr_t wd_in,
		input mips_id_pkg::word_t     imm_in
	);
		mips_id_pkg::decode_t d;
		d           = r_form(op_in, sel_in, wd_in);
		d.reg2_read = 1'b0;
		d.imm       = imm_in;
		return d;
	endfunction

	// jumps and branches without a write
	function automatic mips_id_pkg::decode_t br_form(input logic rd1_in, input logic rd2_in);
		mips_id_pkg::decode_t d;
		d            = '0;
		d.reg1_read  = rd1_in;
		d.reg2_read  = rd2_in;
		d.inst_valid = 1'b1;
		return d;
	endfunction

	function automatic mips_id_pkg::decode_t link_form(
		input mips_id_pkg::reg_addr_t wd_in,
		input logic                   rd1_in
	);
		mips_id_pkg::decode_t d;
		d         = r_form(mips_id_pkg::ALU_LINK, mips_id_pkg::SEL_LINK, wd_in);
		d.reg1_read = rd1_in;
		d.reg2_read = 1'b0;
		d.link    = 1'b1;
		return d;
	endfunction

	always_comb begin
		dec_o = '0;  // unknown encodings stay invalid
		case (op)
			`MIPS_ID_OP_SPECIAL: begin
				case (fn)
					`MIPS_ID_FN_AND:  dec_o = r_form(mips_id_pkg::ALU_AND, mips_id_pkg::SEL_LOGIC, rd);
					`MIPS_ID_FN_OR:   dec_o = r_form(mips_id_pkg::ALU_OR, mips_id_pkg::SEL_LOGIC, rd);
					`MIPS_ID_FN_XOR:  dec_o = r_form(mips_id_pkg::ALU_XOR, mips_id_pkg::SEL_LOGIC, rd);
					`MIPS_ID_FN_NOR:  dec_o = r_form(mips_id_pkg::ALU_NOR, mips_id_pkg::SEL_LOGIC, rd);
					`MIPS_ID_FN_SLT:
						dec_o = r_form(mips_id_pkg::ALU_SLT, mips_id_pkg::SEL_COMPARE, rd);
					`MIPS_ID_FN_SLTU:
						dec_o = r_form(mips_id_pkg::ALU_SLTU, mips_id_pkg::SEL_COMPARE, rd);
					`MIPS_ID_FN_SLL:  dec_o = sh_form(mips_id_pkg::ALU_SLL, rd, imm_sh);
					`MIPS_ID_FN_SRL:  dec_o = sh_form(mips_id_pkg::ALU_SRL, rd, imm_sh);
					`MIPS_ID_FN_SRA:  dec_o = sh_form(mips_id_pkg::ALU_SRA, rd, imm_sh);
					`MIPS_ID_FN_SLLV: dec_o = r_form(mips_id_pkg::ALU_SLL, mips_id_pkg::SEL_SHIFT, rd);
					`MIPS_ID_FN_SRLV: dec_o = r_form(mips_id_pkg::ALU_SRL, mips_id_pkg::SEL_SHIFT, rd);
					`MIPS_ID_FN_SRAV: dec_o = r_form(mips_id_pkg::ALU_SRA, mips_id_pkg::SEL_SHIFT, rd);
					`MIPS_ID_FN_ADD:  dec_o = r_form(mips_id_pkg::ALU_ADD, mips_id_pkg::SEL_ADD, rd);
					`MIPS_ID_FN_ADDU: dec_o = r_form(mips_id_pkg::ALU_ADDU, mips_id_pkg::SEL_ADD, rd);
					`MIPS_ID_FN_SUB:  dec_o = r_form(mips_id_pkg::ALU_SUB, mips_id_pkg::SEL_ADD, rd);
					`MIPS_ID_FN_SUBU: dec_o = r_form(mips_id_pkg::ALU_SUBU, mips_id_pkg::SEL_ADD, rd);
					`MIPS_ID_FN_JR:   dec_o = br_form(1'b1, 1'b0);
					`MIPS_ID_FN_JALR: dec_o = link_form(rd, 1'b1);
					default:          dec_o = '0;
				endcase
			end
			`MIPS_ID_OP_REGIMM: begin
				case (rt)
					`MIPS_ID_RT_BLTZ,
					`MIPS_ID_RT_BGEZ:   dec_o = br_form(1'b1, 1'b0);
					`MIPS_ID_RT_BLTZAL,
					`MIPS_ID_RT_BGEZAL: dec_o = link_form(LINK_REG, 1'b1);  // links even if not taken
					default:            dec_o = '0;
				endcase
			end
			`MIPS_ID_OP_ANDI:
				dec_o = i_form(mips_id_pkg::ALU_AND, mips_id_pkg::SEL_LOGIC, rt, imm_zx);
			`MIPS_ID_OP_ORI:
				dec_o = i_form(mips_id_pkg::ALU_OR, mips_id_pkg::SEL_LOGIC, rt, imm_zx);
			`MIPS_ID_OP_XORI:
				dec_o = i_form(mips_id_pkg::ALU_XOR, mips_id_pkg::SEL_LOGIC, rt, imm_zx);
			`MIPS_ID_OP_LUI:
				dec_o = i_form(mips_id_pkg::ALU_OR, mips_id_pkg::SEL_LOGIC, rt, imm_hi);
			`MIPS_ID_OP_SLTI:
				dec_o = i_form(mips_id_pkg::ALU_SLT, mips_id_pkg::SEL_COMPARE, rt, imm_sx);
			`MIPS_ID_OP_SLTIU:
				dec_o = i_form(mips_id_pkg::ALU_SLTU, mips_id_pkg::SEL_COMPARE, rt, imm_sx);
			`MIPS_ID_OP_ADDI:
				dec_o = i_form(mips_id_pkg::ALU_ADD, mips_id_pkg::SEL_ADD, rt, imm_sx);
			`MIPS_ID_OP_ADDIU:
				dec_o = i_form(mips_id_pkg::ALU_ADDU, mips_id_pkg::SEL_ADD, rt, imm_sx);
			`MIPS_ID_OP_J:    dec_o = br_form(1'b0, 1'b0);
			`MIPS_ID_OP_JAL:  dec_o = link_form(LINK_REG, 1'b0);
			`MIPS_ID_OP_BEQ,
			`MIPS_ID_OP_BNE:  dec_o = br_form(1'b1, 1'b1);
			`MIPS_ID_OP_BLEZ,
			`MIPS_ID_OP_BGTZ: dec_o = br_form(1'b1, 1'b0);
			default:          dec_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: source/branch_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_id_defines.svh"

module branch_unit (
	input  mips_id_pkg::inst_t     inst_i,
	input  mips_id_pkg::word_t     pc_i,
	input  mips_id_pkg::word_t     reg1_data_i,
	input  mips_id_pkg::word_t     reg2_data_i,
	output mips_id_pkg::branch_t   branch_o
);

	mips_id_pkg::opcode_t   op;
	mips_id_pkg::funct_t    fn;
	mips_id_pkg::reg_addr_t rt;
	mips_id_pkg::word_t     pc_plus_4;
	mips_id_pkg::word_t     jump_target;
	mips_id_pkg::word_t     cond_target;
	logic                   rs_neg;
	logic                   rs_zero;
	logic                   taken;
	mips_id_pkg::word_t     target;

	assign op = inst_i[31:26];
	assign rt = inst_i[20:16];
	assign fn = inst_i[5:0];

	assign pc_plus_4   = pc_i + mips_id_pkg::word_t'(4);
	assign jump_target = {pc_plus_4[31:28], inst_i[25:0], 2'b00};
	assign cond_target = pc_plus_4 + {{14{inst_i[15]}}, inst_i[15:0], 2'b00};

	// signed view of rs against zero
	assign rs_neg  = reg1_data_i[`MIPS_ID_WORD_W-1];
	assign rs_zero = (reg1_data_i == '0);

	always_comb begin
		taken  = 1'b0;
		target = cond_target;
		case (op)
			`MIPS_ID_OP_SPECIAL: begin
				if (fn == `MIPS_ID_FN_JR || fn == `MIPS_ID_FN_JALR) begin
					taken  = 1'b1;
					target = reg1_data_i;
				end
			end
			`MIPS_ID_OP_J,
			`MIPS_ID_OP_JAL: begin
				taken  = 1'b1;
				target = jump_target;
			end
			`MIPS_ID_OP_BEQ:  taken = (reg1_data_i == reg2_data_i);
			`MIPS_ID_OP_BNE:  taken = (reg1_data_i != reg2_data_i);
			`MIPS_ID_OP_BLEZ: taken = rs_neg | rs_zero;
			`MIPS_ID_OP_BGTZ: taken = !rs_neg && !rs_zero;
			`MIPS_ID_OP_REGIMM: begin
				case (rt)
					`MIPS_ID_RT_BLTZ, `MIPS_ID_RT_BLTZAL: taken = rs_neg;
					`MIPS_ID_RT_BGEZ, `MIPS_ID_RT_BGEZAL: taken = !rs_neg;
					default:                              taken = 1'b0;
				endcase
			end
			default: taken = 1'b0;
		endcase
	end

	assign branch_o.taken  = taken;
	assign branch_o.target = taken ? target : '0;

endmodule

`default_nettype wire

// File: common/mips_id_pkg.sv
`default_nettype none

`include "mips_id_defines.svh"

package mips_id_pkg;

	typedef logic [`MIPS_ID_WORD_W-1:0]     word_t;     // data, address or immediate
	typedef logic [`MIPS_ID_WORD_W-1:0]     inst_t;
	typedef logic [`MIPS_ID_REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [`MIPS_ID_FIELD_W-1:0]    opcode_t;
	typedef logic [`MIPS_ID_FIELD_W-1:0]    funct_t;
	typedef logic [`MIPS_ID_REG_ADDR_W-1:0] shamt_t;    // shift amount field

	typedef enum logic [3:0] {
		ALU_NOP,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_ADD,
		ALU_ADDU,
		ALU_SUB,
		ALU_SUBU,
		ALU_LINK
	} alu_op_e;

	// result class picked in execute
	typedef enum logic [2:0] {
		SEL_NOP,
		SEL_LOGIC,
		SEL_SHIFT,
		SEL_COMPARE,
		SEL_ADD,
		SEL_LINK
	} alu_sel_e;

	typedef struct packed {
		alu_op_e   alu_op;
		alu_sel_e  alu_sel;
		reg_addr_t wd;
		logic      wreg;
		logic      reg1_read;
		logic      reg2_read;
		word_t     imm;         // already extended
		logic      link;        // operand 1 is pc + 8
		logic      inst_valid;
	} decode_t;

	typedef struct packed {
		alu_op_e   alu_op;
		alu_sel_e  alu_sel;
		word_t     reg1;
		word_t     reg2;
		reg_addr_t wd;
		logic      wreg;
		logic      inst_valid;
	} id_ex_t;

	typedef struct packed {
		logic  taken;
		word_t target;          // zero when not taken
	} branch_t;

endpackage

`default_nettype wire

// File: common/mips_id_defines.svh
`ifndef MIPS_ID_DEFINES_SVH
`define MIPS_ID_DEFINES_SVH

`define MIPS_ID_WORD_W       32
`define MIPS_ID_REG_ADDR_W   5
`define MIPS_ID_FIELD_W      6   // opcode and function fields
`define MIPS_ID_IMM_W        16
`define MIPS_ID_LINK_REG     31  // return address register

// primary opcodes
`define MIPS_ID_OP_SPECIAL   6'b000000
`define MIPS_ID_OP_REGIMM    6'b000001
`define MIPS_ID_OP_J         6'b000010
`define MIPS_ID_OP_JAL       6'b000011
`define MIPS_ID_OP_BEQ       6'b000100
`define MIPS_ID_OP_BNE       6'b000101
`define MIPS_ID_OP_BLEZ      6'b000110
`define MIPS_ID_OP_BGTZ      6'b000111
`define MIPS_ID_OP_ADDI      6'b001000
`define MIPS_ID_OP_ADDIU     6'b001001
`define MIPS_ID_OP_SLTI      6'b001010
`define MIPS_ID_OP_SLTIU     6'b001011
`define MIPS_ID_OP_ANDI      6'b001100
`define MIPS_ID_OP_ORI       6'b001101
`define MIPS_ID_OP_XORI      6'b001110
`define MIPS_ID_OP_LUI       6'b001111

// SPECIAL function codes
`define MIPS_ID_FN_SLL       6'b000000
`define MIPS_ID_FN_SRL       6'b000010
`define MIPS_ID_FN_SRA       6'b000011
`define MIPS_ID_FN_SLLV      6'b000100
`define MIPS_ID_FN_SRLV      6'b000110
`define MIPS_ID_FN_SRAV      6'b000111
`define MIPS_ID_FN_JR        6'b001000
`define MIPS_ID_FN_JALR      6'b001001
`define MIPS_ID_FN_ADD       6'b100000
`define MIPS_ID_FN_ADDU      6'b100001
`define MIPS_ID_FN_SUB       6'b100010
`define MIPS_ID_FN_SUBU      6'b100011
`define MIPS_ID_FN_AND       6'b100100
`define MIPS_ID_FN_OR        6'b100101
`define MIPS_ID_FN_XOR       6'b100110
`define MIPS_ID_FN_NOR       6'b100111
`define MIPS_ID_FN_SLT       6'b101010
`define MIPS_ID_FN_SLTU      6'b101011

// REGIMM rt codes
`define MIPS_ID_RT_BLTZ      5'b00000
`define MIPS_ID_RT_BGEZ      5'b00001
`define MIPS_ID_RT_BLTZAL    5'b10000
`define MIPS_ID_RT_BGEZAL    5'b10001

`endif
